// File: list.f
+incdir+test
hdl/sw_pkg.sv
hdl/sw_cell.sv
hdl/sw_cell_array.sv
hdl/sw_query_loader.sv
hdl/sw_max_tracker.sv
hdl/sw_array_ctrl.sv
hdl/sw_top.sv
test/tb_sw_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_sw_top
FILELIST  := list.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_sw_ref.svh
`ifndef TB_SW_REF_SVH
`define TB_SW_REF_SVH

function automatic int max3(input int a, input int b, input int c);
	int m;
	m = (a > b) ? a : b;
	return (m > c) ? m : c;
endfunction

function automatic base_t base_code(input byte c);
	case (c)
		"C": return 2'd1;
		"G": return 2'd2;
		"T": return 2'd3;
		default: return 2'd0;
	endcase
endfunction

function automatic string base_char(input int k);
	case (k)
		1: return "C";
		2: return "G";
		3: return "T";
		default: return "A";
	endcase
endfunction

// Local alignment with affine gaps, one target column at a time
// E runs along the target, F along the query
function automatic int ref_score(input string q, input string t, input int m, input int mm,
		input int o, input int e);
	int h_col [PE_COUNT+1];
	int e_col [PE_COUNT+1];
	int h_diag, h_up, f_up, h_old, e_new, f_new, s, h, best;
	best = 0;
	for (int i = 0; i <= PE_COUNT; i++) begin
		h_col[i] = 0;
		e_col[i] = 0;
	end
	for (int j = 0; j < t.len(); j++) begin
		h_diag = 0;
		h_up = 0;
		f_up = 0;
		for (int i = 1; i <= q.len(); i++) begin
			h_old = h_col[i];
			e_new = max3(h_old - o, e_col[i] - e, 0);
			f_new = max3(h_up - o, f_up - e, 0);
			s = (q[i-1] == t[j]) ? h_diag + m : h_diag - mm;
			// E and F are floored, so H never drops below zero
			h = max3(e_new, f_new, s);
			h_diag = h_old;
			h_col[i] = h;
			e_col[i] = e_new;
			h_up = h;
			f_up = f_new;
			best = (h > best) ? h : best;
		end
	end
	return best;
endfunction

task automatic random_job(inout integer seed, input int max_t, output string q,
		output string t, output int m, output int mm, output int o, output int e);
	int q_len;
	int t_len;
	q = "";
	t = "";
	q_len = 1 + int'({$random(seed)} % PE_COUNT);
	t_len = 1 + int'({$random(seed)} % max_t);
	for (int i = 0; i < q_len; i++) begin
		q = {q, base_char(int'({$random(seed)} % 4))};
	end
	for (int j = 0; j < t_len; j++) begin
		t = {t, base_char(int'({$random(seed)} % 4))};
	end
	m = 1 + int'({$random(seed)} % 4);
	mm = 1 + int'({$random(seed)} % 3);
	o = 2 + int'({$random(seed)} % 4);
	e = 1 + int'({$random(seed)} % 2);
endtask

`endif

// File: test/tb_sw_top.sv
`timescale 1ns/10ps

module tb_sw_top;
	import sw_pkg::*;

	`include "tb_sw_ref.svh"

	localparam int RESET_CYCLES = 16;
	localparam int NUM_FIXED = 6;
	localparam int NUM_JOBS = 16;
	localparam int MAX_T = 12;
	localparam int WATCHDOG_CYCLES = NUM_JOBS * (PE_COUNT + MAX_T) * 8 + 2 * RESET_CYCLES;
	// Last drain step lands PE_COUNT cycles after the target ack falls
	// and done follows it by two cycles
	localparam int DONE_DELAY = PE_COUNT + 2;

	logic clk, rst_n;
	score_t i_match, i_mismatch, i_gap_open, i_gap_extend;
	logic i_q_req, i_q_last, i_t_req, i_t_last;
	base_t i_q_base, i_t_base;
	logic o_q_ack, o_t_ack, o_done;
	score_t o_score;

	// Expected score below zero means use the reference
	string job_name [NUM_JOBS];
	string job_q [NUM_JOBS];
	string job_t [NUM_JOBS];
	score_t job_m [NUM_JOBS];
	score_t job_mm [NUM_JOBS];
	score_t job_o [NUM_JOBS];
	score_t job_e [NUM_JOBS];
	int job_exp [NUM_JOBS];

	integer seed;
	int errors;
	int tests_run;
	int tests_failed;

	sw_top u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_match      (i_match),
		.i_mismatch   (i_mismatch),
		.i_gap_open   (i_gap_open),
		.i_gap_extend (i_gap_extend),
		.i_q_req      (i_q_req),
		.i_q_base     (i_q_base),
		.i_q_last     (i_q_last),
		.i_t_req      (i_t_req),
		.i_t_base     (i_t_base),
		.i_t_last     (i_t_last),
		.o_q_ack      (o_q_ack),
		.o_t_ack      (o_t_ack),
		.o_done       (o_done),
		.o_score      (o_score)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_score(input string name, input score_t got, input score_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic set_row(input int k, input string name, input string q, input string t,
			input int m, input int mm, input int o, input int e, input int exp);
		job_name[k] = name;
		job_q[k] = q;
		job_t[k] = t;
		job_m[k] = score_t'(m);
		job_mm[k] = score_t'(mm);
		job_o[k] = score_t'(o);
		job_e[k] = score_t'(e);
		job_exp[k] = exp;
	endtask

	// Outputs are read at the edge, before the DUT updates them
	task automatic push_query(input base_t b, input logic last);
		@(posedge clk);
		i_q_req <= 1'b1;
		i_q_base <= b;
		i_q_last <= last;
		do @(posedge clk); while (o_q_ack !== 1'b1);
		i_q_req <= 1'b0;
		do @(posedge clk); while (o_q_ack !== 1'b0);
	endtask

	task automatic push_target(input base_t b, input logic last);
		@(posedge clk);
		i_t_req <= 1'b1;
		i_t_base <= b;
		i_t_last <= last;
		do @(posedge clk); while (o_t_ack !== 1'b1);
		i_t_req <= 1'b0;
		do @(posedge clk); while (o_t_ack !== 1'b0);
	endtask

	task automatic run_job(input int k);
		string q;
		string t;
		int exp_score;
		int waited;
		int errors_before;
		score_t got;
		q = job_q[k];
		t = job_t[k];
		errors_before = errors;
		if (job_exp[k] < 0) begin
			exp_score = ref_score(q, t, int'(job_m[k]), int'(job_mm[k]), int'(job_o[k]),
				int'(job_e[k]));
		end else begin
			exp_score = job_exp[k];
		end
		@(posedge clk);
		i_match <= job_m[k];
		i_mismatch <= job_mm[k];
		i_gap_open <= job_o[k];
		i_gap_extend <= job_e[k];
		for (int i = 0; i < q.len(); i++) begin
			push_query(base_code(q[i]), i == q.len() - 1);
		end
		for (int j = 0; j < t.len(); j++) begin
			push_target(base_code(t[j]), j == t.len() - 1);
		end
		// Count from the fall of the last target ack
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (o_done !== 1'b1);
		got = o_score;
		check_score("o_score", got, score_t'(exp_score));
		if (waited != DONE_DELAY) begin
			$display("Job %0d: o_done came %0d cycles after the last target ack fell, not %0d",
				k, waited, DONE_DELAY);
			errors++;
		end
		@(posedge clk);
		check_bit("o_done", o_done, 1'b0);
		tests_run++;
		if (errors != errors_before) begin
			tests_failed++;
		end
		$display("job %0d (%s) q=%s t=%s: score %0d expected %0d, %s", k, job_name[k], q, t,
			got, exp_score, (errors == errors_before) ? "ok" : "FAILED");
	endtask

	initial begin
		string q, t;
		int m, mm, o, e;
		seed = 90052;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rst_n <= 1'b0;
		i_match <= '0;
		i_mismatch <= '0;
		i_gap_open <= '0;
		i_gap_extend <= '0;
		i_q_req <= 1'b0;
		i_q_base <= '0;
		i_q_last <= 1'b0;
		i_t_req <= 1'b0;
		i_t_base <= '0;
		i_t_last <= 1'b0;

		//      row name              query       target         m  mm o  e  score
		set_row(0, "exact match",     "ACGTACGT", "ACGTACGT",    2, 1, 3, 1, 16);
		set_row(1, "no common base",  "AAAA",     "CGTCGT",      2, 1, 3, 1, 0);
		set_row(2, "one-base gap",    "ACGTACGT", "ACGTTACGT",   2, 2, 3, 1, 13);
		set_row(3, "three-base gap",  "ACGTACGT", "ACGTGGGACGT", 2, 2, 3, 1, 11);
		set_row(4, "gap in target",   "ACGTTACG", "ACGTACG",     2, 2, 3, 1, 11);
		set_row(5, "short query",     "GATC",     "TTGATCCGA",   3, 1, 4, 1, -1);
		for (int k = NUM_FIXED; k < NUM_JOBS; k++) begin
			random_job(seed, MAX_T, q, t, m, mm, o, e);
			set_row(k, "random", q, t, m, mm, o, e, -1);
		end

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		check_bit("o_q_ack", o_q_ack, 1'b0);
		check_bit("o_t_ack", o_t_ack, 1'b0);
		check_bit("o_done", o_done, 1'b0);
		check_score("o_score", o_score, '0);
		tests_run++;
		if (errors != 0) begin
			tests_failed++;
		end
		$display("reset state: %s", (errors == 0) ? "ok" : "FAILED");

		// Jobs run back to back, so each one relies on the previous clear
		for (int k = 0; k < NUM_JOBS; k++) begin
			run_job(k);
		end

		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Run timed out after %0d cycles before the job table finished",
			WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

// File: hdl/sw_top.sv
`timescale 1ns/10ps

module sw_top (
	input  logic           clk,
	input  logic           rst_n,
	input  sw_pkg::score_t i_match,
	input  sw_pkg::score_t i_mismatch,
	input  sw_pkg::score_t i_gap_open,
	input  sw_pkg::score_t i_gap_extend,
	input  logic           i_q_req,
	input  sw_pkg::base_t  i_q_base,
	input  logic           i_q_last,
	input  logic           i_t_req,
	input  sw_pkg::base_t  i_t_base,
	input  logic           i_t_last,
	output logic           o_q_ack,
	output logic           o_t_ack,
	output logic           o_done,
	output sw_pkg::score_t o_score
);
	import sw_pkg::*;

	logic q_push, q_clear, step, step_valid, max_clear, h_valid;
	base_t step_base;
	pe_mask_t pe_en;
	logic [PE_IDX_W-1:0] q_len;
	base_t [PE_COUNT-1:0] q_bases;
	score_t [PE_COUNT-1:0] h_all;
	score_t job_match, job_mismatch, job_open, job_extend;

	sw_array_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_q_req      (i_q_req),
		.i_q_last     (i_q_last),
		.i_t_req      (i_t_req),
		.i_t_base     (i_t_base),
		.i_t_last     (i_t_last),
		.i_q_len      (q_len),
		.o_q_ack      (o_q_ack),
		.o_t_ack      (o_t_ack),
		.o_q_push     (q_push),
		.o_q_clear    (q_clear),
		.o_step       (step),
		.o_step_valid (step_valid),
		.o_t_base     (step_base),
		.o_pe_en      (pe_en),
		.o_max_clear  (max_clear),
		.o_done       (o_done)
	);

	sw_query_loader u_loader (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_clear      (q_clear),
		.i_push       (q_push),
		.i_base       (i_q_base),
		.i_match      (i_match),
		.i_mismatch   (i_mismatch),
		.i_gap_open   (i_gap_open),
		.i_gap_extend (i_gap_extend),
		.o_q_bases    (q_bases),
		.o_q_len      (q_len),
		.o_match      (job_match),
		.o_mismatch   (job_mismatch),
		.o_gap_open   (job_open),
		.o_gap_extend (job_extend)
	);

	sw_cell_array u_array (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_step       (step),
		.i_valid      (step_valid),
		.i_t_base     (step_base),
		.i_pe_en      (pe_en),
		.i_q_bases    (q_bases),
		.i_match      (job_match),
		.i_mismatch   (job_mismatch),
		.i_gap_open   (job_open),
		.i_gap_extend (job_extend),
		.i_clear      (max_clear),
		.o_h_all      (h_all),
		.o_h_valid    (h_valid)
	);

	sw_max_tracker u_max (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_clear (max_clear),
		.i_valid (h_valid),
		.i_h_all (h_all),
		.o_best  (o_score)
	);

endmodule

// File: hdl/sw_array_ctrl.sv
`timescale 1ns/10ps

module sw_array_ctrl (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_q_req,
	input  logic                          i_q_last,
	input  logic                          i_t_req,
	input  sw_pkg::base_t                 i_t_base,
	input  logic                          i_t_last,
	input  logic [sw_pkg::PE_IDX_W-1:0]   i_q_len,
	output logic                          o_q_ack,
	output logic                          o_t_ack,
	output logic                          o_q_push,
	output logic                          o_q_clear,
	output logic                          o_step,
	output logic                          o_step_valid,
	output sw_pkg::base_t                 o_t_base,
	output sw_pkg::pe_mask_t              o_pe_en,
	output logic                          o_max_clear,
	output logic                          o_done
);
	import sw_pkg::*;

	ctrl_state_t state;
	logic [PE_IDX_W-1:0] cnt;
	logic t_last_seen;
	logic q_accept, t_accept, q_full;
	pe_mask_t len_mask;
	base_t t_base_r;

	// A new req is taken only while ack is low
	assign q_accept = i_q_req & ~o_q_ack & (state == IDLE || state == LOAD);
	assign t_accept = i_t_req & ~o_t_ack & (state == RUN) & ~t_last_seen;
	assign q_full   = i_q_last | (i_q_len == PE_IDX_W'(PE_COUNT - 1));

	assign o_q_push    = q_accept;
	assign o_max_clear = q_accept & (state == IDLE);
	assign o_q_clear   = (state == DONE);

	// Cells past the query length stay out of the score
	always_comb begin
		for (int i = 0; i < PE_COUNT; i++) begin
			len_mask[i] = (PE_IDX_W'(i) < i_q_len);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= IDLE;
			cnt          <= '0;
			t_last_seen  <= 1'b0;
			o_q_ack      <= 1'b0;
			o_t_ack      <= 1'b0;
			o_step       <= 1'b0;
			o_step_valid <= 1'b0;
			o_pe_en      <= '0;
			o_done       <= 1'b0;
		end else begin
			if (q_accept) begin
				o_q_ack <= 1'b1;
			end else if (!i_q_req) begin
				o_q_ack <= 1'b0;
			end
			if (t_accept) begin
				o_t_ack <= 1'b1;
			end else if (!i_t_req) begin
				o_t_ack <= 1'b0;
			end
			// Drain steps carry no valid target
			o_step       <= t_accept | (state == DRAIN);
			o_step_valid <= t_accept;
			o_pe_en      <= len_mask;
			o_done       <= (state == DONE);

			case (state)
				IDLE, LOAD: begin
					t_last_seen <= 1'b0;
					if (q_accept) begin
						state <= q_full ? RUN : LOAD;
					end
				end
				RUN: begin
					if (t_accept && i_t_last) begin
						t_last_seen <= 1'b1;
					end
					// Drain starts as the last target ack falls
					if (t_last_seen && o_t_ack && !i_t_req) begin
						state <= DRAIN;
						cnt   <= '0;
					end
				end
				DRAIN: begin
					cnt <= cnt + 1'b1;
					if (cnt == PE_IDX_W'(PE_COUNT - 2)) begin
						state <= FLUSH;
						cnt   <= '0;
					end
				end
				FLUSH: begin
					cnt <= cnt + 1'b1;
					if (cnt == PE_IDX_W'(FLUSH_LEN - 1)) begin
						state <= DONE;
						cnt   <= '0;
					end
				end
				DONE: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (t_accept) begin
			t_base_r <= i_t_base;
		end
	end

	assign o_t_base = t_base_r;

endmodule

// File: hdl/sw_max_tracker.sv
`timescale 1ns/10ps

module sw_max_tracker (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  i_clear,
	input  logic                                  i_valid,
	input  sw_pkg::score_t [sw_pkg::PE_COUNT-1:0] i_h_all,
	output sw_pkg::score_t                        o_best
);
	import sw_pkg::*;

	score_t [PE_COUNT/2-1:0] pair_r;
	logic pair_v;
	score_t stage2_max;
	score_t best_r;

	// Stage one takes pairwise maxima
	always_ff @(posedge clk) begin
		if (i_valid) begin
			for (int k = 0; k < PE_COUNT / 2; k++) begin
				pair_r[k] <= (i_h_all[2*k] > i_h_all[2*k+1]) ? i_h_all[2*k] : i_h_all[2*k+1];
			end
		end
	end

	always_comb begin
		stage2_max = pair_r[0];
		for (int k = 1; k < PE_COUNT / 2; k++) begin
			if (pair_r[k] > stage2_max) begin
				stage2_max = pair_r[k];
			end
		end
	end

	// Stage two folds into the running best
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pair_v <= 1'b0;
			best_r <= '0;
		end else begin
			pair_v <= i_valid & ~i_clear;
			if (i_clear) begin
				best_r <= '0;
			end else if (pair_v && stage2_max > best_r) begin
				best_r <= stage2_max;
			end
		end
	end

	assign o_best = best_r;

endmodule

// File: hdl/sw_query_loader.sv
`timescale 1ns/10ps

module sw_query_loader (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  i_clear,
	input  logic                                  i_push,
	input  sw_pkg::base_t                         i_base,
	input  sw_pkg::score_t                        i_match,
	input  sw_pkg::score_t                        i_mismatch,
	input  sw_pkg::score_t                        i_gap_open,
	input  sw_pkg::score_t                        i_gap_extend,
	output sw_pkg::base_t  [sw_pkg::PE_COUNT-1:0] o_q_bases,
	output logic           [sw_pkg::PE_IDX_W-1:0] o_q_len,
	output sw_pkg::score_t                        o_match,
	output sw_pkg::score_t                        o_mismatch,
	output sw_pkg::score_t                        o_gap_open,
	output sw_pkg::score_t                        o_gap_extend
);
	import sw_pkg::*;

	base_t [PE_COUNT-1:0] q_bases;
	logic [PE_IDX_W-1:0] q_len;
	score_t match_r, mismatch_r, open_r, extend_r;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q_len <= '0;
		end else if (i_clear) begin
			q_len <= '0;
		end else if (i_push) begin
			q_len <= q_len + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_push) begin
			q_bases[q_len[PE_IDX_W-2:0]] <= i_base;
			// Scoring is frozen at the first base of a job
			if (q_len == '0) begin
				match_r    <= i_match;
				mismatch_r <= i_mismatch;
				open_r     <= i_gap_open;
				extend_r   <= i_gap_extend;
			end
		end
	end

	assign o_q_bases    = q_bases;
	assign o_q_len      = q_len;
	assign o_match      = match_r;
	assign o_mismatch   = mismatch_r;
	assign o_gap_open   = open_r;
	assign o_gap_extend = extend_r;

endmodule

// File: hdl/sw_cell_array.sv
`timescale 1ns/10ps

module sw_cell_array (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   i_step,
	input  logic                                   i_valid,
	input  sw_pkg::base_t                          i_t_base,
	input  sw_pkg::pe_mask_t                       i_pe_en,
	input  sw_pkg::base_t  [sw_pkg::PE_COUNT-1:0]  i_q_bases,
	input  sw_pkg::score_t                         i_match,
	input  sw_pkg::score_t                         i_mismatch,
	input  sw_pkg::score_t                         i_gap_open,
	input  sw_pkg::score_t                         i_gap_extend,
	input  logic                                   i_clear,
	output sw_pkg::score_t [sw_pkg::PE_COUNT-1:0]  o_h_all,
	output logic                                   o_h_valid
);
	import sw_pkg::*;

	// Index 0 is the array input, index g+1 the output of cell g
	base_t  [PE_COUNT:0] t_chain;
	logic   [PE_COUNT:0] v_chain;
	score_t [PE_COUNT:0] h_chain;
	score_t [PE_COUNT:0] f_chain;
	score_t [PE_COUNT:0] d_chain;
	logic step_q;

	assign t_chain[0] = i_t_base;
	assign v_chain[0] = i_valid;
	assign h_chain[0] = '0;
	assign f_chain[0] = '0;
	assign d_chain[0] = '0;

	for (genvar g = 0; g < PE_COUNT; g++) begin : g_cell
		sw_cell u_cell (
			.clk          (clk),
			.rst_n        (rst_n),
			.i_step       (i_step),
			.i_valid      (v_chain[g]),
			.i_en         (i_pe_en[g]),
			.i_q_base     (i_q_bases[g]),
			.i_t_base     (t_chain[g]),
			.i_h_left     (h_chain[g]),
			.i_h_diag     (d_chain[g]),
			.i_f_left     (f_chain[g]),
			.i_match      (i_match),
			.i_mismatch   (i_mismatch),
			.i_gap_open   (i_gap_open),
			.i_gap_extend (i_gap_extend),
			.o_t_base     (t_chain[g+1]),
			.o_valid      (v_chain[g+1]),
			.o_h          (h_chain[g+1]),
			.o_f          (f_chain[g+1]),
			.o_h_diag     (d_chain[g+1])
		);
		assign o_h_all[g] = h_chain[g+1];
	end

	// Marks the cycle right after a step, when cell outputs are fresh
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step_q <= 1'b0;
		end else begin
			step_q <= i_step & ~i_clear;
		end
	end

	assign o_h_valid = step_q & (|v_chain[PE_COUNT:1]);

endmodule

// File: hdl/sw_cell.sv
`timescale 1ns/10ps

module sw_cell (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           i_step,
	input  logic           i_valid,
	input  logic           i_en,
	input  sw_pkg::base_t  i_q_base,
	input  sw_pkg::base_t  i_t_base,
	input  sw_pkg::score_t i_h_left,
	input  sw_pkg::score_t i_h_diag,
	input  sw_pkg::score_t i_f_left,
	input  sw_pkg::score_t i_match,
	input  sw_pkg::score_t i_mismatch,
	input  sw_pkg::score_t i_gap_open,
	input  sw_pkg::score_t i_gap_extend,
	output sw_pkg::base_t  o_t_base,
	output logic           o_valid,
	output sw_pkg::score_t o_h,
	output sw_pkg::score_t o_f,
	output sw_pkg::score_t o_h_diag
);
	import sw_pkg::*;

	score_t h_r, e_r, f_r, diag_r;
	score_t e_new, f_new, s_diag, h_new;
	base_t t_r;
	logic valid_r;

	// Subtraction that stops at zero
	function automatic score_t sat_sub(input score_t a, input score_t b);
		return (a > b) ? score_t'(a - b) : '0;
	endfunction

	function automatic score_t max2(input score_t a, input score_t b);
		return (a > b) ? a : b;
	endfunction

	always_comb begin
		// E runs along the target, F comes down from the left cell
		e_new = max2(sat_sub(h_r, i_gap_open), sat_sub(e_r, i_gap_extend));
		f_new = max2(sat_sub(i_h_left, i_gap_open), sat_sub(i_f_left, i_gap_extend));
		if (i_q_base == i_t_base) begin
			s_diag = i_h_diag + i_match;
		end else begin
			s_diag = sat_sub(i_h_diag, i_mismatch);
		end
		h_new = max2(max2(e_new, f_new), s_diag);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			h_r     <= '0;
			e_r     <= '0;
			f_r     <= '0;
			diag_r  <= '0;
			valid_r <= 1'b0;
		end else if (i_step) begin
			valid_r <= i_valid;
			diag_r  <= h_r;
			if (i_valid) begin
				h_r <= h_new;
				e_r <= e_new;
				f_r <= f_new;
			end else begin
				// Empty step leaves the cell ready for column zero
				h_r <= '0;
				e_r <= '0;
				f_r <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_step) begin
			t_r <= i_t_base;
		end
	end

	assign o_t_base = t_r;
	assign o_valid  = valid_r;
	assign o_h      = i_en ? h_r : '0;
	assign o_f      = f_r;
	assign o_h_diag = diag_r;

endmodule

// File: hdl/sw_pkg.sv
package sw_pkg;

	// Nucleotide codes A=0 C=1 G=2 T=3
	localparam int BASE_W = 2;

	// Scores and penalties share one unsigned width
	localparam int SCORE_W = 12;

	// Cells in the array, also the longest query
	localparam int PE_COUNT = 8;
	localparam int PE_IDX_W = 4;

	// Tracker pipeline depth after the final step
	localparam int FLUSH_LEN = 2;

	typedef logic [BASE_W-1:0] base_t;
	typedef logic [SCORE_W-1:0] score_t;
	typedef logic [PE_COUNT-1:0] pe_mask_t;

	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		LOAD  = 3'd1,
		RUN   = 3'd2,
		DRAIN = 3'd3,
		FLUSH = 3'd4,
		DONE  = 3'd5
	} ctrl_state_t;

endpackage
